// File: compile.f
source/mipsPkg.sv
source/registerFile.sv
source/arithUnit.sv
source/dataPath.sv
source/mainControl.sv
source/multicycleCpu.sv
dv/multicycleCpu_assertions.sv
dv/tbMulticycleCpu.sv

// File: runSim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass or fail by the log.

cd "$(dirname "$0")" || exit 1

buildDir=build
logFile="$buildDir/sim.log"
simBin=simMulticycleCpu

mkdir -p "$buildDir"
if [ $? -ne 0 ]; then
    echo "cannot create $buildDir"
    exit 1
fi

verilator --binary --timing --assert -f compile.f --top-module tbMulticycleCpu \
    -Mdir "$buildDir/obj_dir" -o "$simBin"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$buildDir/obj_dir/$simBin" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
fi

if grep -qx "Verification passed" "$logFile"; then
    exit 0
fi
echo "pass message not found in $logFile"
exit 1

// File: dv/tbMulticycleCpu.sv
`timescale 1ns/1ns

module tbMulticycleCpu;

    localparam int halfPeriod = 5;
    localparam int resetCycles = 10;
    localparam int memWords = 256;

    typedef struct packed {
        mipsPkg::dataWord addr;
        mipsPkg::dataWord value;
    } storeEntry;

    logic             clk = 1'b0;
    logic             rstN;
    mipsPkg::dataWord readData;
    mipsPkg::dataWord memAddr;
    mipsPkg::dataWord writeData;
    logic             memRead;
    logic             memWrite;

    mipsPkg::dataWord mem [memWords];
    mipsPkg::dataWord image [memWords];
    mipsPkg::dataWord modelMem [memWords];
    mipsPkg::dataWord model [mipsPkg::regCount];
    storeEntry        expStores [$];
    string            expNames [$];
    int               progLen = 0;
    int               seed = 32'h7984_4aa6;
    logic             programReady = 1'b0;
    mipsPkg::dataWord finalPc;

    multicycleCpu i_multicycleCpu (
        .clk      (clk),
        .rstN     (rstN),
        .readData (readData),
        .memAddr  (memAddr),
        .writeData(writeData),
        .memRead  (memRead),
        .memWrite (memWrite)
    );

    always #halfPeriod clk = ~clk;

    // program image is copied into memory during reset.
    assign readData = mem[memAddr[9:2]];

    always @(posedge clk) begin
        if (!rstN) begin
            mem <= image;
        end else if (memWrite) begin
            mem[memAddr[9:2]] <= writeData;
        end
    end

    function automatic mipsPkg::dataWord signExtend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [15:0] randomHalf();
        int r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic mipsPkg::dataWord encodeReg(input logic [5:0] op, input mipsPkg::regAddr rs,
            input mipsPkg::regAddr rt, input mipsPkg::regAddr rd, input logic [5:0] fn);
        return {op, rs, rt, rd, 5'b0, fn};
    endfunction

    function automatic mipsPkg::dataWord encodeImm(input logic [5:0] op, input mipsPkg::regAddr rs,
            input mipsPkg::regAddr rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input mipsPkg::dataWord word);
        image[progLen[7:0]] = word;
        progLen++;
    endtask

    task automatic emitImm(input logic [5:0] op, input mipsPkg::regAddr rt,
            input mipsPkg::regAddr rs, input logic [15:0] imm);
        emit(encodeImm(op, rs, rt, imm));
        case (op)
            mipsPkg::opAndi: model[rt] = model[rs] & {16'b0, imm};
            mipsPkg::opOri:  model[rt] = model[rs] | {16'b0, imm};
            default:         model[rt] = model[rs] + signExtend(imm);
        endcase
    endtask

    task automatic emitAlu(input logic [5:0] op, input logic [5:0] fn, input mipsPkg::regAddr rd,
            input mipsPkg::regAddr rs, input mipsPkg::regAddr rt);
        mipsPkg::dataWord a;
        mipsPkg::dataWord b;
        a = model[rs];
        b = model[rt];
        emit(encodeReg(op, rs, rt, rd, fn));
        if (op == mipsPkg::opSpecial2) begin
            model[rd] = a * b;
        end else begin
            case (fn)
                mipsPkg::fnSub: model[rd] = a - b;
                mipsPkg::fnAnd: model[rd] = a & b;
                mipsPkg::fnOr:  model[rd] = a | b;
                mipsPkg::fnSlt: model[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:        model[rd] = a + b;
            endcase
        end
    endtask

    task automatic emitStore(input string name, input mipsPkg::regAddr rt,
            input mipsPkg::regAddr base, input logic [15:0] offset);
        mipsPkg::dataWord addr;
        addr = model[base] + signExtend(offset);
        emit(encodeImm(mipsPkg::opSw, base, rt, offset));
        expStores.push_back({addr, model[rt]});
        expNames.push_back(name);
        modelMem[addr[9:2]] = model[rt];
    endtask

    task automatic emitLoad(input mipsPkg::regAddr rt, input mipsPkg::regAddr base,
            input logic [15:0] offset);
        mipsPkg::dataWord addr;
        addr = model[base] + signExtend(offset);
        emit(encodeImm(mipsPkg::opLw, base, rt, offset));
        model[rt] = modelMem[addr[9:2]];
    endtask

    task automatic buildProgram();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immC;
        logic [15:0] immD;
        logic [15:0] immE;
        image = '{default: '0};
        modelMem = '{default: '0};
        model = '{default: '0};
        // r1 is odd and negative while r2 never is, so beq r1,r2 falls through.
        immA = randomHalf() | 16'h8001;
        immB = randomHalf();
        immC = randomHalf();
        immD = randomHalf() | 16'h8000;
        immE = randomHalf() | 16'h8000;
        emitImm(mipsPkg::opAddi, 5'd1, 5'd0, immA);
        emitImm(mipsPkg::opOri, 5'd2, 5'd0, immB);
        emitImm(mipsPkg::opAddi, 5'd3, 5'd1, immC);
        emitImm(mipsPkg::opAndi, 5'd4, 5'd1, immD);
        emitImm(mipsPkg::opOri, 5'd5, 5'd2, immE);
        emitImm(mipsPkg::opAddi, 5'd10, 5'd0, 16'h0200);
        emitImm(mipsPkg::opAddi, 5'd11, 5'd0, 16'h0300);
        emitAlu(mipsPkg::opRtype, mipsPkg::fnAdd, 5'd6, 5'd1, 5'd2);
        emitStore("add", 5'd6, 5'd10, 16'h0000);
        emitAlu(mipsPkg::opRtype, mipsPkg::fnSub, 5'd6, 5'd1, 5'd2);
        emitStore("sub", 5'd6, 5'd10, 16'h0004);
        emitAlu(mipsPkg::opRtype, mipsPkg::fnAnd, 5'd6, 5'd1, 5'd2);
        emitStore("and", 5'd6, 5'd10, 16'h0008);
        emitAlu(mipsPkg::opRtype, mipsPkg::fnOr, 5'd6, 5'd1, 5'd2);
        emitStore("or", 5'd6, 5'd10, 16'h000c);
        emitAlu(mipsPkg::opRtype, mipsPkg::fnSlt, 5'd6, 5'd1, 5'd2);
        emitStore("slt", 5'd6, 5'd10, 16'h0010);
        emitAlu(mipsPkg::opRtype, mipsPkg::fnSlt, 5'd6, 5'd2, 5'd1);
        emitStore("sltReverse", 5'd6, 5'd10, 16'h0014);
        // full width multiplier so every shift-add step counts.
        emitAlu(mipsPkg::opSpecial2, mipsPkg::mulFunct, 5'd7, 5'd1, 5'd1);
        emitStore("mul", 5'd7, 5'd10, 16'h0018);
        emitStore("addi", 5'd3, 5'd10, 16'h001c);
        emitStore("andi", 5'd4, 5'd10, 16'h0020);
        emitStore("ori", 5'd5, 5'd10, 16'h0024);
        // offset of -8 from the second base.
        emitStore("swNegative", 5'd1, 5'd11, 16'hfff8);
        emitLoad(5'd12, 5'd11, 16'hfff8);
        emitStore("lw", 5'd12, 5'd10, 16'h0028);
        // taken beq jumps over a store that must never show up.
        emit(encodeImm(mipsPkg::opBeq, 5'd1, 5'd1, 16'h0001));
        emit(encodeImm(mipsPkg::opSw, 5'd10, 5'd4, 16'h003c));
        emitStore("beqTaken", 5'd2, 5'd10, 16'h002c);
        emit(encodeImm(mipsPkg::opBeq, 5'd1, 5'd2, 16'h0001));
        emitStore("beqNotTaken", 5'd3, 5'd10, 16'h0030);
        finalPc = 32'(progLen * 4);
        emit(encodeImm(mipsPkg::opBeq, 5'd0, 5'd0, 16'hffff));
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkStore();
        storeEntry expected;
        string     name;
        if (expStores.size() == 0) begin
            abortRun($sformatf("unexpected store of %h to %h after the last expected store",
                writeData, memAddr));
        end else begin
            expected = expStores.pop_front();
            name = expNames.pop_front();
            assert (memAddr == expected.addr) else begin
                abortRun($sformatf("MISMATCH %s address: expected %h actual %h",
                    name, expected.addr, memAddr));
            end
            assert (writeData == expected.value) else begin
                abortRun($sformatf("MISMATCH %s value: expected %h actual %h",
                    name, expected.value, writeData));
            end
        end
    endtask

    task automatic endRun();
        if (expStores.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abortRun($sformatf("final loop reached with %0d expected stores missing",
                expStores.size()));
        end
    endtask

    initial begin
        rstN <= 1'b0;
        buildProgram();
        programReady = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

    // outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (rstN && memWrite) begin
            checkStore();
        end
        if (rstN && memRead && (memAddr == finalPc)) begin
            endRun();
        end
    end

    initial begin : watchdog
        int limitCycles;
        wait (programReady);
        limitCycles = progLen * (4 + mipsPkg::mulCycles + 1) + resetCycles;
        repeat (limitCycles) @(posedge clk);
        abortRun($sformatf("timeout, final loop not reached within %0d cycles", limitCycles));
    end

endmodule

// File: dv/multicycleCpu_assertions.sv
`timescale 1ns/1ns

module multicycleCpu_assertions (
    input logic               clk,
    input logic               rstN,
    input mipsPkg::dataWord   readData,
    input mipsPkg::dataWord   memAddr,
    input logic               memRead,
    input logic               memWrite,
    input mipsPkg::ctrlBundle ctrl
);

    // fetch to fetch distance of a mul.
    localparam logic [7:0] mulGap = 8'(4 + mipsPkg::mulCycles);

    logic       fetch;
    logic       mulFetch;
    logic       mulActive;
    logic [7:0] sinceMul;

    assign fetch = memRead && !ctrl.iorD;
    assign mulFetch = fetch && (readData[31:26] == mipsPkg::opSpecial2)
                      && (readData[5:0] == mipsPkg::mulFunct);

    // cycles since the last mul fetch.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mulActive <= 1'b0;
            sinceMul  <= '0;
        end else if (mulFetch) begin
            mulActive <= 1'b1;
            sinceMul  <= 8'd1;
        end else if (fetch) begin
            mulActive <= 1'b0;
        end else if (mulActive) begin
            sinceMul <= sinceMul + 8'd1;
        end
    end

    resetNoWrite: assert property (@(posedge clk) !rstN |-> !memWrite)
        else $error("memWrite high during reset");

    firstFetch: assert property (@(posedge clk)
        $rose(rstN) |-> memRead && !memWrite && (memAddr == mipsPkg::resetPc))
        else $error("first access after reset is not a fetch from the reset address");

    noReadWrite: assert property (@(posedge clk) disable iff (!rstN) !(memRead && memWrite))
        else $error("memRead and memWrite high together");

    fetchAligned: assert property (@(posedge clk) disable iff (!rstN)
        fetch |-> (memAddr[1:0] == 2'b00))
        else $error("fetch address not word aligned");

    mulQuiet: assert property (@(posedge clk) disable iff (!rstN)
        mulActive && (memRead || memWrite) |-> fetch && (sinceMul == mulGap))
        else $error("memory access during a multiply or next fetch at the wrong cycle");

    mulBounded: assert property (@(posedge clk) disable iff (!rstN)
        mulActive |-> (sinceMul <= mulGap))
        else $error("no fetch within the multiply window");

endmodule

bind multicycleCpu multicycleCpu_assertions i_assertions (
    .clk     (clk),
    .rstN    (rstN),
    .readData(readData),
    .memAddr (memAddr),
    .memRead (memRead),
    .memWrite(memWrite),
    .ctrl    (ctrl)
);

// File: source/multicycleCpu.sv
`timescale 1ns/1ns

module multicycleCpu (
    input  logic             clk,
    input  logic             rstN,
    input  mipsPkg::dataWord readData,
    output mipsPkg::dataWord memAddr,
    output mipsPkg::dataWord writeData,
    output logic             memRead,
    output logic             memWrite
);

    mipsPkg::ctrlBundle ctrl;
    mipsPkg::dataWord   instr;
    logic               stall;

    mainControl i_mainControl (
        .clk    (clk),
        .rstN   (rstN),
        .instr  (instr),
        .stall  (stall),
        .ctrl   (ctrl),
        .memRead(memRead)
    );

    // branch qualification with zero happens inside the datapath.
    dataPath i_dataPath (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .readData (readData),
        .memAddr  (memAddr),
        .writeData(writeData),
        .instr    (instr),
        .zero     (),
        .stall    (stall)
    );

    assign memWrite = ctrl.memWrite;

endmodule

// File: source/mainControl.sv
`timescale 1ns/1ns

module mainControl (
    input  logic               clk,
    input  logic               rstN,
    input  mipsPkg::dataWord   instr,
    input  logic               stall,
    output mipsPkg::ctrlBundle ctrl,
    output logic               memRead
);

    mipsPkg::ctrlStateE state;
    mipsPkg::ctrlStateE stateNext;
    mipsPkg::opcodeE    opcode;
    mipsPkg::functE     funct;
    mipsPkg::aluOpE     regAluOp;
    mipsPkg::aluOpE     immAluOp;
    logic               isMul;

    assign opcode = mipsPkg::opcodeE'(instr[31:26]);
    assign funct  = mipsPkg::functE'(instr[5:0]);
    assign isMul  = (opcode == mipsPkg::opSpecial2) && (instr[5:0] == mipsPkg::mulFunct);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= mipsPkg::sFetch;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        case (state)
            mipsPkg::sFetch: stateNext = mipsPkg::sDecode;
            mipsPkg::sDecode: begin
                case (opcode)
                    mipsPkg::opLw, mipsPkg::opSw: stateNext = mipsPkg::sMemAddr;
                    mipsPkg::opBeq:               stateNext = mipsPkg::sBranch;
                    mipsPkg::opRtype:             stateNext = mipsPkg::sExecute;
                    mipsPkg::opSpecial2: begin
                        stateNext = isMul ? mipsPkg::sExecute : mipsPkg::sFetch;
                    end
                    mipsPkg::opAddi, mipsPkg::opAndi, mipsPkg::opOri: begin
                        stateNext = mipsPkg::sImmExec;
                    end
                    default: stateNext = mipsPkg::sFetch;
                endcase
            end
            mipsPkg::sMemAddr: begin
                stateNext = (opcode == mipsPkg::opLw) ? mipsPkg::sMemRead : mipsPkg::sMemWrite;
            end
            mipsPkg::sMemRead: stateNext = mipsPkg::sMemWb;
            // wait out the multiplier.
            mipsPkg::sExecute: stateNext = stall ? mipsPkg::sExecute : mipsPkg::sAluWb;
            mipsPkg::sImmExec: stateNext = mipsPkg::sImmWb;
            default:           stateNext = mipsPkg::sFetch;
        endcase
    end

    always_comb begin
        if (opcode == mipsPkg::opSpecial2) begin
            regAluOp = mipsPkg::aluMul;
        end else begin
            case (funct)
                mipsPkg::fnSub: regAluOp = mipsPkg::aluSub;
                mipsPkg::fnAnd: regAluOp = mipsPkg::aluAnd;
                mipsPkg::fnOr:  regAluOp = mipsPkg::aluOr;
                mipsPkg::fnSlt: regAluOp = mipsPkg::aluSlt;
                default:        regAluOp = mipsPkg::aluAdd;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            mipsPkg::opAndi: immAluOp = mipsPkg::aluAnd;
            mipsPkg::opOri:  immAluOp = mipsPkg::aluOr;
            default:         immAluOp = mipsPkg::aluAdd;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = mipsPkg::aluAdd;
        ctrl.aluSrcB = mipsPkg::srcBReg;
        memRead = 1'b0;
        case (state)
            mipsPkg::sFetch: begin
                memRead = 1'b1;
                ctrl.irWrite = 1'b1;
                ctrl.pcEn = 1'b1;
                ctrl.aluSrcB = mipsPkg::srcBFour;
            end
            // branch target computed ahead of time.
            mipsPkg::sDecode: ctrl.aluSrcB = mipsPkg::srcBImmSh;
            mipsPkg::sMemAddr: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = mipsPkg::srcBImm;
            end
            mipsPkg::sMemRead: begin
                memRead = 1'b1;
                ctrl.iorD = 1'b1;
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = mipsPkg::srcBImm;
            end
            // address is recomputed so readData stays valid here.
            mipsPkg::sMemWb: begin
                ctrl.iorD = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = mipsPkg::srcBImm;
            end
            mipsPkg::sMemWrite: begin
                ctrl.iorD = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = mipsPkg::srcBImm;
            end
            mipsPkg::sExecute: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluOp = regAluOp;
            end
            mipsPkg::sAluWb: begin
                ctrl.regDst = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            mipsPkg::sBranch: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluOp = mipsPkg::aluSub;
                ctrl.pcSrc = 1'b1;
                ctrl.pcEn = 1'b1;
            end
            mipsPkg::sImmExec: begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = mipsPkg::srcBImm;
                ctrl.extSel = (opcode == mipsPkg::opAndi) || (opcode == mipsPkg::opOri);
                ctrl.aluOp = immAluOp;
            end
            mipsPkg::sImmWb: ctrl.regWrite = 1'b1;
            default: ctrl.aluOp = mipsPkg::aluAdd;
        endcase
    end

endmodule

// File: source/dataPath.sv
`timescale 1ns/1ns

module dataPath (
    input  logic               clk,
    input  logic               rstN,
    input  mipsPkg::ctrlBundle ctrl,
    input  mipsPkg::dataWord   readData,
    output mipsPkg::dataWord   memAddr,
    output mipsPkg::dataWord   writeData,
    output mipsPkg::dataWord   instr,
    output logic               zero,
    output logic               stall
);

    mipsPkg::dataWord pc;
    mipsPkg::dataWord pcNext;
    mipsPkg::dataWord instrReg;
    mipsPkg::dataWord regA;
    mipsPkg::dataWord regB;
    mipsPkg::dataWord aluOut;
    mipsPkg::dataWord rfValueA;
    mipsPkg::dataWord rfValueB;
    mipsPkg::dataWord extImm;
    mipsPkg::dataWord srcA;
    mipsPkg::dataWord srcB;
    mipsPkg::dataWord aluResult;
    mipsPkg::dataWord regWriteValue;
    mipsPkg::regAddr  regWriteAddr;
    logic             pcLoad;

    // branch target sits in aluOut since decode.
    assign pcNext = ctrl.pcSrc ? aluOut : aluResult;
    assign pcLoad = ctrl.pcEn && (!ctrl.pcSrc || zero);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= mipsPkg::resetPc;
        end else if (pcLoad) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            instrReg <= readData;
        end
    end

    always_ff @(posedge clk) begin
        regA   <= rfValueA;
        regB   <= rfValueB;
        aluOut <= aluResult;
    end

    assign memAddr   = ctrl.iorD ? aluOut : pc;
    assign writeData = regB;
    assign instr     = instrReg;

    assign regWriteAddr  = ctrl.regDst ? instrReg[15:11] : instrReg[20:16];
    assign regWriteValue = ctrl.memToReg ? readData : aluOut;

    // extSel high selects zero extension for andi and ori.
    assign extImm = ctrl.extSel ? {16'b0, instrReg[15:0]}
                                : {{16{instrReg[15]}}, instrReg[15:0]};

    assign srcA = ctrl.aluSrcA ? regA : pc;

    always_comb begin
        case (ctrl.aluSrcB)
            mipsPkg::srcBReg:  srcB = regB;
            mipsPkg::srcBFour: srcB = 32'd4;
            mipsPkg::srcBImm:  srcB = extImm;
            default:           srcB = extImm << 2;
        endcase
    end

    registerFile i_registerFile (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (instrReg[25:21]),
        .readAddrB (instrReg[20:16]),
        .writeAddr (regWriteAddr),
        .writeEn   (ctrl.regWrite),
        .writeValue(regWriteValue),
        .readValueA(rfValueA),
        .readValueB(rfValueB)
    );

    arithUnit i_arithUnit (
        .clk   (clk),
        .rstN  (rstN),
        .aluOp (ctrl.aluOp),
        .srcA  (srcA),
        .srcB  (srcB),
        .result(aluResult),
        .zero  (zero),
        .stall (stall)
    );

endmodule

// File: source/arithUnit.sv
`timescale 1ns/1ns

module arithUnit (
    input  logic             clk,
    input  logic             rstN,
    input  mipsPkg::aluOpE   aluOp,
    input  mipsPkg::dataWord srcA,
    input  mipsPkg::dataWord srcB,
    output mipsPkg::dataWord result,
    output logic             zero,
    output logic             stall
);

    mipsPkg::dataWord mulAcc;
    mipsPkg::dataWord mulCand;
    mipsPkg::dataWord mulPlier;
    mipsPkg::mulCnt   mulCount;
    logic             mulBusy;
    logic             mulDone;
    logic             mulStart;
    logic             lessThan;

    assign mulStart = (aluOp == mipsPkg::aluMul) && !mulBusy && !mulDone;
    // the start cycle already counts as the first step.
    assign stall = mulStart || mulBusy;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mulBusy  <= 1'b0;
            mulDone  <= 1'b0;
            mulCount <= '0;
        end else if (mulStart) begin
            mulBusy  <= 1'b1;
            mulCount <= mipsPkg::mulCntOne;
        end else if (mulBusy) begin
            mulCount <= mulCount + mipsPkg::mulCntOne;
            if (mulCount == mipsPkg::mulCntLast) begin
                mulBusy <= 1'b0;
                mulDone <= 1'b1;
            end
        end else if (aluOp != mipsPkg::aluMul) begin
            mulDone <= 1'b0;
        end
    end

    // shift-add steps keep only the low word.
    always_ff @(posedge clk) begin
        if (mulStart) begin
            mulAcc   <= srcB[0] ? srcA : '0;
            mulCand  <= srcA << 1;
            mulPlier <= srcB >> 1;
        end else if (mulBusy) begin
            mulAcc   <= mulAcc + (mulPlier[0] ? mulCand : '0);
            mulCand  <= mulCand << 1;
            mulPlier <= mulPlier >> 1;
        end
    end

    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluOp)
            mipsPkg::aluSub: result = srcA - srcB;
            mipsPkg::aluAnd: result = srcA & srcB;
            mipsPkg::aluOr:  result = srcA | srcB;
            mipsPkg::aluSlt: result = {{(mipsPkg::wordWidth - 1){1'b0}}, lessThan};
            mipsPkg::aluMul: result = mulAcc;
            default:         result = srcA + srcB;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic             clk,
    input  logic             rstN,
    input  mipsPkg::regAddr  readAddrA,
    input  mipsPkg::regAddr  readAddrB,
    input  mipsPkg::regAddr  writeAddr,
    input  logic             writeEn,
    input  mipsPkg::dataWord writeValue,
    output mipsPkg::dataWord readValueA,
    output mipsPkg::dataWord readValueB
);

    mipsPkg::dataWord regs [mipsPkg::regCount];

    // register 0 is never written, so it stays at its reset value.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < mipsPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeValue;
        end
    end

    assign readValueA = regs[readAddrA];
    assign readValueB = regs[readAddrB];

endmodule

// File: source/mipsPkg.sv
package mipsPkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount = 32;

    // iterations of the shift-add multiplier.
    localparam int mulCycles = 32;
    localparam int mulCntWidth = $clog2(mulCycles);

    typedef logic [wordWidth-1:0] dataWord;
    typedef logic [regAddrWidth-1:0] regAddr;
    typedef logic [mulCntWidth-1:0] mulCnt;

    localparam dataWord resetPc = '0;
    localparam mulCnt mulCntOne = mulCnt'(1);
    localparam mulCnt mulCntLast = mulCnt'(mulCycles - 1);

    // funct field of mul inside the SPECIAL2 opcode.
    localparam logic [5:0] mulFunct = 6'h02;

    // second ALU operand select.
    localparam logic [1:0] srcBReg = 2'd0;
    localparam logic [1:0] srcBFour = 2'd1;
    localparam logic [1:0] srcBImm = 2'd2;
    localparam logic [1:0] srcBImmSh = 2'd3;

    typedef enum logic [5:0] {
        opRtype    = 6'h00,
        opBeq      = 6'h04,
        opAddi     = 6'h08,
        opAndi     = 6'h0c,
        opOri      = 6'h0d,
        opSpecial2 = 6'h1c,
        opLw       = 6'h23,
        opSw       = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functE;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4,
        aluMul = 3'd5
    } aluOpE;

    typedef enum logic [3:0] {
        sFetch,
        sDecode,
        sMemAddr,
        sMemRead,
        sMemWb,
        sMemWrite,
        sExecute,
        sAluWb,
        sBranch,
        sImmExec,
        sImmWb
    } ctrlStateE;

    typedef struct packed {
        logic       pcEn;
        logic       iorD;
        logic       irWrite;
        logic       regDst;
        logic       memToReg;
        logic       regWrite;
        logic       aluSrcA;
        logic [1:0] aluSrcB;
        logic       extSel;
        aluOpE      aluOp;
        logic       pcSrc;
        logic       memWrite;
    } ctrlBundle;

endpackage
